// ==== tb.f ====
audio_pkg.sv
i2s_mic_receiver.sv
sample_fifo.sv
i2s_dac_transmitter.sv
level_meter.sv
audio_loop_top.sv
tb_i2s_mic_model.sv
tb_audio_loop.sv

// ==== Makefile ====
# Verilator build and run of the audio loopback testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f tb.f --top-module tb_audio_loop -Mdir obj_dir
	./obj_dir/Vtb_audio_loop | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb_audio_loop.sv ====
`default_nettype none

module tb_audio_loop;

    timeunit 1ns;
    timeprecision 100ps;

    import audio_pkg::*;

    localparam int  mic_half_bit  = 2;
    localparam int  dac_half_bit  = 2;
    localparam int  fifo_depth    = 8;
    localparam int  w_led         = 8;
    localparam int  mic_frame_clk = 128 * mic_half_bit;
    localparam int  dac_frame_clk = 64 * dac_half_bit;
    localparam int  n_mic_frames  = 300;
    localparam int  n_dac_frames  = n_mic_frames * mic_frame_clk / dac_frame_clk - 40;
    localparam real watchdog_ns   = 1.5 * n_mic_frames * mic_frame_clk * 10.0;

    logic clk;
    logic rst_n;
    wire  mic_sd, mic_sck, mic_ws, mic_lr;
    wire  dac_bclk, dac_lrck, dac_sdata;
    wire  overflow, underrun;
    wire  [w_led - 1:0] led;

    int               errors          = 0;
    int               checks          = 0;
    int               frames_done     = 0;
    int               carried_frames  = 0;
    int               underrun_frames = 0;
    int               next_idx        = 0;  // Next expected sample in the model queue
    logic [w_led - 1:0] model_led     = '0;

    // Output decoder state
    logic               bclk_prev;
    logic               lrck_at_rise;
    logic [31:0]        frame_bits;
    int                 lr_falls;
    logic               frame_underrun;
    logic [w_led - 1:0] frame_led;

    audio_loop_top # (
        .mic_half_bit ( mic_half_bit ),
        .dac_half_bit ( dac_half_bit ),
        .fifo_depth   ( fifo_depth   ),
        .w_led        ( w_led        )
    ) UUT (
        .clk (clk), .rst_n (rst_n),
        .mic_sd (mic_sd), .mic_sck (mic_sck), .mic_ws (mic_ws), .mic_lr (mic_lr),
        .dac_bclk (dac_bclk), .dac_lrck (dac_lrck), .dac_sdata (dac_sdata),
        .led (led), .overflow (overflow), .underrun (underrun)
    );

    tb_i2s_mic_model mic (.clk (clk), .mic_sck (mic_sck), .mic_ws (mic_ws), .mic_sd (mic_sd));

    always #5 clk = ~clk;

    // ------------------------------
    // Checks

    task automatic check_pcm(string name, pcm_t actual, pcm_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s: got %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    task automatic check_led(string name, logic [w_led - 1:0] actual,
                             logic [w_led - 1:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s: got %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    task automatic check_flag(string name, logic actual, logic expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s: got %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    // Bit k lights at magnitude 2**(15 - w_led + k)
    function automatic logic [w_led - 1:0] thermometer(pcm_t s);
        int                 mag;
        logic [w_led - 1:0] bar;
        mag = int'(s);
        if (mag < 0)
            mag = -mag;
        if (mag > 32767)
            mag = 32767;  // Saturates at full scale
        for (int k = 0; k < w_led; k++)
            bar[k] = (mag >= (1 << (15 - w_led + k)));
        return bar;
    endfunction

    task automatic score_frame(logic [31:0] bits, logic was_underrun,
                               logic [w_led - 1:0] seen_led);
        pcm_t    left;
        pcm_t    right;
        pcm_t    expected;
        sample_t src;
        left  = bits[31:16];
        right = bits[15:0];
        if (was_underrun) begin
            underrun_frames++;
            check_pcm("dac left", left, '0);
            check_pcm("dac right", right, '0);
        end else if (next_idx >= mic.sent_q.size()) begin
            errors++;
            $display("Frame %0d carried data although no microphone sample was pending",
                     frames_done);
        end else begin
            src = mic.sent_q[next_idx];
            next_idx++;
            carried_frames++;
            expected = pcm_t'(src >> (sample_w - pcm_w));  // Upper 16 bits of the sample
            check_pcm("dac left", left, expected);
            check_pcm("dac right", right, expected);
            model_led = thermometer(expected);
        end
        check_led("led", seen_led, model_led);  // Held through underrun frames
        check_flag("overflow", overflow, 1'b0);
        check_flag("mic_lr", mic_lr, 1'b0);
        frames_done++;
    endtask

    // ------------------------------
    // DAC stream decoder on the falling clk edge

    always @(negedge clk) begin
        if (!rst_n) begin
            bclk_prev    = 1'b0;
            lrck_at_rise = 1'b0;
            lr_falls     = 0;
            frame_bits   = '0;
        end else begin
            if (dac_bclk && !bclk_prev) begin
                frame_bits = {frame_bits[30:0], dac_sdata};
                // First rise after LR goes low carries the last bit of the frame
                if (!dac_lrck && lrck_at_rise) begin
                    if (lr_falls > 0)
                        score_frame(frame_bits, frame_underrun, frame_led);
                    lr_falls++;
                    frame_underrun = underrun;
                end
                if (dac_lrck && !lrck_at_rise)
                    frame_led = led;  // Mid frame, after the load has settled
                lrck_at_rise = dac_lrck;
            end
            bclk_prev = dac_bclk;
        end
    end

    // ------------------------------
    // Main sequence and watchdog

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;

        @(negedge clk);
        check_flag("overflow", overflow, 1'b0);
        check_flag("underrun", underrun, 1'b0);
        check_flag("mic_lr", mic_lr, 1'b0);
        check_led("led", led, '0);

        wait (frames_done >= n_dac_frames);

        if (underrun_frames == 0) begin
            errors++;
            $display("No DAC frame underran during the run");
        end
        if (carried_frames == 0) begin
            errors++;
            $display("No DAC frame carried a microphone sample");
        end
        if (mic.sent_q.size() - next_idx > fifo_depth + 1) begin
            errors++;
            $display("Microphone samples were lost on the way to the DAC");
        end
        check_flag("overflow", overflow, 1'b0);

        $display("Frames: %0d carried, %0d underrun; checks: %0d; errors: %0d",
                 carried_frames, underrun_frames, checks, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired at %0t with %0d of %0d frames decoded",
                 $time, frames_done, n_dac_frames);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_i2s_mic_model.sv ====
`default_nettype none

module tb_i2s_mic_model (
    input  wire  clk,
    input  wire  mic_sck,
    input  wire  mic_ws,
    output logic mic_sd
);

    timeunit 1ns;
    timeprecision 100ps;

    import audio_pkg::*;

    integer      seed = 32'h54054e19;
    logic [31:0] rnd;
    sample_t     cur;
    sample_t     sent_q [$];  // Left samples in the order they went out
    int          pos;         // Bit clocks since word select went low
    logic        sck_prev;
    logic        ws_prev;

    initial begin
        mic_sd   = 1'b0;
        pos      = 0;
        sck_prev = 1'b0;
        ws_prev  = 1'b0;
    end

    // Data changes after the falling bit clock, MSB on the second bit of the slot
    always @(posedge clk) begin
        #1;
        if (sck_prev && !mic_sck) begin
            if (ws_prev && !mic_ws)
                pos = 0;  // New frame
            else
                pos = pos + 1;

            if (!mic_ws && pos == 1) begin
                rnd = $random(seed);
                cur = rnd[sample_w - 1:0];
                sent_q.push_back(cur);
            end

            if (!mic_ws && pos >= 1 && pos <= sample_w)
                mic_sd = cur[sample_w - pos];
            else
                mic_sd = 1'b0;  // Right slot and padding bits
        end
        sck_prev = mic_sck;
        ws_prev  = mic_ws;
    end

endmodule

`default_nettype wire

// ==== audio_loop_top.sv ====
`default_nettype none

module audio_loop_top
# (
    parameter mic_half_bit = 16,
              dac_half_bit = 32,
              fifo_depth   = 8,
              w_led        = 8
)
(
    input  wire                 clk,
    input  wire                 rst_n,

    input  wire                 mic_sd,
    output wire                 mic_sck,
    output wire                 mic_ws,
    output wire                 mic_lr,

    output wire                 dac_bclk,
    output wire                 dac_lrck,
    output wire                 dac_sdata,

    output wire [w_led - 1:0]   led,
    output wire                 overflow,
    output wire                 underrun
);

    import audio_pkg::*;

    // ------------------------------
    // Audio path

    sample_t mic_sample;
    logic    mic_push;
    sample_t fifo_head;
    logic    fifo_empty;
    logic    fifo_pop;
    pcm_t    play_sample;
    logic    play_load;

    i2s_mic_receiver # (.mic_half_bit (mic_half_bit))
    i_mic
    (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .mic_sd      ( mic_sd      ),
        .mic_sck     ( mic_sck     ),
        .mic_ws      ( mic_ws      ),
        .mic_lr      ( mic_lr      ),
        .sample      ( mic_sample  ),
        .sample_push ( mic_push    )
    );

    sample_fifo # (.fifo_depth (fifo_depth))
    i_fifo
    (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .wr_data     ( mic_sample  ),
        .push        ( mic_push    ),
        .rd_data     ( fifo_head   ),
        .pop         ( fifo_pop    ),
        .empty       ( fifo_empty  ),
        .overflow    ( overflow    )
    );

    i2s_dac_transmitter # (.dac_half_bit (dac_half_bit))
    i_dac
    (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .rd_data     ( fifo_head   ),
        .empty       ( fifo_empty  ),
        .pop         ( fifo_pop    ),
        .dac_bclk    ( dac_bclk    ),
        .dac_lrck    ( dac_lrck    ),
        .dac_sdata   ( dac_sdata   ),
        .underrun    ( underrun    ),
        .play_sample ( play_sample ),
        .play_load   ( play_load   )
    );

    level_meter # (.w_led (w_led))
    i_meter
    (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .play_sample ( play_sample ),
        .play_load   ( play_load   ),
        .led         ( led         )
    );

endmodule

`default_nettype wire

// ==== level_meter.sv ====
`default_nettype none

module level_meter
# (
    parameter w_led = 8  // At most 15
)
(
    input  wire                  clk,
    input  wire                  rst_n,

    input  wire audio_pkg::pcm_t play_sample,
    input  wire                  play_load,

    output logic [w_led - 1:0]   led
);

    import audio_pkg::*;

    logic [pcm_w - 1:0] magnitude;
    logic [w_led - 1:0] bar;

    // ------------------------------
    // Magnitude, saturated at 32767

    always_comb begin
        if (!play_sample[pcm_w - 1])
            magnitude = play_sample;
        else if (play_sample[pcm_w - 2:0] == '0)
            magnitude = {1'b0, {(pcm_w - 1){1'b1}}};  // Most negative code
        else
            magnitude = ~play_sample + 1'b1;
    end

    // Thermometer code, top LED at half of full scale
    always_comb begin
        for (int k = 0; k < w_led; k++)
            bar[k] = magnitude >= (pcm_w'(1) << (pcm_w - 1 - w_led + k));
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            led <= '0;
        else if (play_load)
            led <= bar;  // Held until the next frame with data
    end

endmodule

`default_nettype wire

// ==== i2s_dac_transmitter.sv ====
`default_nettype none

module i2s_dac_transmitter
# (
    parameter dac_half_bit = 32
)
(
    input  wire                     clk,
    input  wire                     rst_n,

    input  wire audio_pkg::sample_t rd_data,
    input  wire                     empty,
    output logic                    pop,

    output logic                    dac_bclk,
    output logic                    dac_lrck,
    output logic                    dac_sdata,
    output logic                    underrun,

    output audio_pkg::pcm_t         play_sample,
    output logic                    play_load
);

    import audio_pkg::*;

    localparam w_half     = dac_half_bit > 1 ? $clog2(dac_half_bit) : 1;
    localparam frame_bits = 2 * dac_slot_bits;
    localparam w_bit      = $clog2(frame_bits);

    logic [w_half     - 1:0] half_cnt;
    logic [w_bit      - 1:0] bit_cnt;
    logic [frame_bits - 1:0] tx_shift;
    logic                    half_tick;
    logic                    bclk_fall;
    logic                    frame_start;
    pcm_t                    head_pcm;

    // ------------------------------
    // Bit clock and LR clock

    assign half_tick = (half_cnt == w_half'(dac_half_bit - 1));
    assign bclk_fall = half_tick & dac_bclk;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            half_cnt <= '0;
            dac_bclk <= 1'b0;
        end else if (half_tick) begin
            half_cnt <= '0;
            dac_bclk <= ~dac_bclk;
        end else begin
            half_cnt <= half_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            bit_cnt <= '0;
        else if (bclk_fall)
            bit_cnt <= bit_cnt + 1'b1;
    end

    assign dac_lrck = bit_cnt[w_bit - 1];  // Low for the left slot

    // LR clock is about to go low
    assign frame_start = bclk_fall && bit_cnt == w_bit'(frame_bits - 1);

    // ------------------------------
    // Frame load and serializer

    assign head_pcm = rd_data[sample_w - 1 -: pcm_w];  // Drop the low 8 bits
    assign pop      = frame_start && !empty;

    // Output lags the shifter by one bit clock, so the right LSB
    // goes out in the first bit of the next left slot
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_shift  <= '0;
            dac_sdata <= 1'b0;
        end else if (bclk_fall) begin
            dac_sdata <= tx_shift[frame_bits - 1];

            if (frame_start)
                tx_shift <= pop ? {head_pcm, head_pcm} : '0;  // Same on both channels
            else
                tx_shift <= tx_shift << 1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            underrun  <= 1'b0;
            play_load <= 1'b0;
        end else begin
            play_load <= pop;

            if (frame_start)
                underrun <= empty;  // Held for the whole frame
        end
    end

    always_ff @(posedge clk) begin
        if (pop)
            play_sample <= head_pcm;
    end

    // Data only moves on the falling edge of the bit clock
    a_sdata_stable : assert property (
        @(posedge clk) disable iff (!rst_n)
        dac_bclk |-> $stable(dac_sdata)
    ) else $error("dac_sdata changed while dac_bclk was high");

endmodule

`default_nettype wire

// ==== sample_fifo.sv ====
`default_nettype none

module sample_fifo
# (
    parameter fifo_depth = 8
)
(
    input  wire                     clk,
    input  wire                     rst_n,

    input  wire audio_pkg::sample_t wr_data,
    input  wire                     push,

    output audio_pkg::sample_t      rd_data,
    input  wire                     pop,

    output logic                    empty,
    output logic                    overflow
);

    import audio_pkg::*;

    localparam w_ptr = fifo_depth > 1 ? $clog2(fifo_depth) : 1;
    localparam w_cnt = $clog2(fifo_depth + 1);

    sample_t            mem [fifo_depth];
    logic [w_ptr - 1:0] wr_ptr;
    logic [w_ptr - 1:0] rd_ptr;
    logic [w_cnt - 1:0] count;
    logic               full;
    logic               wr_en;
    logic               rd_en;

    // ------------------------------
    // Status

    assign full  = (count == w_cnt'(fifo_depth));
    assign empty = (count == '0);

    // A full FIFO still takes a push when a pop frees a slot
    assign wr_en = push && (!full || pop);
    assign rd_en = pop && !empty;

    assign rd_data = mem[rd_ptr];  // Head of the queue

    // ------------------------------
    // Storage

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_ptr] <= wr_data;
    end

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;

            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;

            if (wr_en && !rd_en)
                count <= count + 1'b1;
            else if (rd_en && !wr_en)
                count <= count - 1'b1;

            if (push && !wr_en)
                overflow <= 1'b1;  // Sticky until reset
        end
    end

    // The consumer never reads an empty queue
    a_no_pop_when_empty : assert property (
        @(posedge clk) disable iff (!rst_n)
        pop |-> !empty
    ) else $error("pop while the FIFO is empty");

endmodule

`default_nettype wire

// ==== i2s_mic_receiver.sv ====
`default_nettype none

module i2s_mic_receiver
# (
    parameter mic_half_bit = 16
)
(
    input  wire                clk,
    input  wire                rst_n,

    input  wire                mic_sd,
    output logic               mic_sck,
    output logic               mic_ws,
    output logic               mic_lr,

    output audio_pkg::sample_t sample,
    output logic               sample_push
);

    import audio_pkg::*;

    localparam w_half    = mic_half_bit > 1 ? $clog2(mic_half_bit) : 1;
    localparam w_bit     = $clog2(2 * mic_slot_bits);
    localparam first_bit = 1;          // MSB follows the WS edge by one bit clock
    localparam last_bit  = sample_w;   // LSB position in the slot

    logic [w_half - 1:0] half_cnt;
    logic [w_bit  - 1:0] bit_cnt;
    logic                half_tick;
    logic                sck_rise;
    logic                sck_fall;
    logic                in_window;
    sample_t             shift_q;

    // ------------------------------
    // Bit clock divider

    assign half_tick = (half_cnt == w_half'(mic_half_bit - 1));
    assign sck_rise  = half_tick & ~mic_sck;
    assign sck_fall  = half_tick &  mic_sck;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            half_cnt <= '0;
            mic_sck  <= 1'b0;
        end else if (half_tick) begin
            half_cnt <= '0;
            mic_sck  <= ~mic_sck;
        end else begin
            half_cnt <= half_cnt + 1'b1;
        end
    end

    // Slot position moves on the falling edge, as WS does
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            bit_cnt <= '0;
        else if (sck_fall)
            bit_cnt <= bit_cnt + 1'b1;
    end

    assign mic_ws = bit_cnt[w_bit - 1];  // Low during the left slot
    assign mic_lr = 1'b0;                // Microphone answers in the left slot

    // ------------------------------
    // Sample capture

    assign in_window = !mic_ws
                    && bit_cnt >= w_bit'(first_bit)
                    && bit_cnt <= w_bit'(last_bit);

    // Data is taken on the rising edge of the bit clock, MSB first
    always_ff @(posedge clk) begin
        if (sck_rise && in_window)
            shift_q <= {shift_q[sample_w - 2:0], mic_sd};
    end

    // One strobe right after the LSB has been shifted in
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            sample_push <= 1'b0;
        else
            sample_push <= sck_rise && in_window && bit_cnt == w_bit'(last_bit);
    end

    assign sample = shift_q;  // Stable until the next left slot

    // Samples only come out of the left slot
    a_push_left_only : assert property (
        @(posedge clk) disable iff (!rst_n)
        sample_push |-> !mic_ws && $past(!mic_ws)
    ) else $error("sample_push outside the left slot");

endmodule

`default_nettype wire

// ==== audio_pkg.sv ====
`default_nettype none

package audio_pkg;

    // ------------------------------
    // Microphone side

    localparam int sample_w      = 24;  // INMP441 style sample
    localparam int mic_slot_bits = 32;  // Two slots, 64 bit clocks per frame

    // One microphone sample, two's complement
    typedef logic signed [sample_w - 1:0] sample_t;

    // ------------------------------
    // DAC side

    localparam int pcm_w         = 16;
    localparam int dac_slot_bits = 16;  // Two slots, 32 bit clocks per frame

    // Upper pcm_w bits of a sample_t
    typedef logic signed [pcm_w - 1:0] pcm_t;

endpackage

`default_nettype wire
